// File: source/storeBufPkg.sv
`default_nettype none

package storeBufPkg;

    // ##############################
    // Sizes
    // ##############################

    localparam int numCores = 16;
    localparam int numSlots = 16;
    localparam int wordsPerLine = 4;
    localparam int numRows = numSlots / wordsPerLine;
    localparam int wordWidth = 16;

    localparam int slotWidth = $clog2(numSlots);
    localparam int rowWidth = $clog2(numRows);
    localparam int lineWidth = wordsPerLine * wordWidth;

    // ##############################
    // Types
    // ##############################

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [slotWidth-1:0] slotT;
    typedef logic [rowWidth-1:0] rowT;
    typedef logic [lineWidth-1:0] lineDataT;   // Lowest slot of the row on top

    // Merged writes of one barrier cycle
    typedef struct packed {
        logic [numSlots-1:0] writeMask;        // One bit per slot
        wordT [numSlots-1:0] words;            // Indexed by slot
    } commitT;

    // Flushed line tagged with its row
    typedef struct packed {
        rowT row;
        lineDataT data;
    } lineT;

endpackage

`default_nettype wire

// File: source/handshakeSlice.sv
`default_nettype none
`timescale 1ns/100ps

module handshakeSlice #(
    parameter type payloadT = logic
) (
    input logic clk,
    input logic rstN,
    input logic inValid,
    output logic inReady,
    input payloadT inData,
    output logic outValid,
    input logic outReady,
    output payloadT outData
);

    logic loadItem;

    // Empty, or the held item leaves this cycle
    assign inReady = !outValid || outReady;
    assign loadItem = inValid && inReady;

    // ##############################
    // Single entry
    // ##############################

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            outData <= '0;
        end
        else
        begin
            if (inReady)
            begin
                outValid <= inValid;
            end
            if (loadItem)
            begin
                outData <= inData;
            end
        end
    end

    // A stalled item stays put until the consumer takes it
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(outData))
    )
    else $error("handshakeSlice: output changed while stalled");

endmodule

`default_nettype wire

// File: source/storeMerge.sv
`default_nettype none
`timescale 1ns/100ps

module storeMerge (
    input logic clk,
    input logic rstN,
    input logic [storeBufPkg::numCores-1:0] coreEn,
    input storeBufPkg::slotT coreAddr [storeBufPkg::numCores],
    input storeBufPkg::wordT coreData [storeBufPkg::numCores],
    input logic [storeBufPkg::numCores-1:0] coreMemWr,
    output storeBufPkg::commitT commit,
    output logic commitValid
);

    logic barrier;
    logic anyEnabled;
    storeBufPkg::commitT merged;

    assign barrier = &coreMemWr;                // Every core has reached the store
    assign anyEnabled = |coreEn;

    // ##############################
    // Per-slot priority merge
    // ##############################

    // Cores are scanned upwards, so a later core overrides an earlier one
    // that addresses the same slot
    always_comb
    begin
        merged = '0;
        for (int c = 0; c < storeBufPkg::numCores; c++)
        begin
            if (coreEn[c])
            begin
                merged.writeMask[coreAddr[c]] = 1'b1;
                merged.words[coreAddr[c]] = coreData[c];
            end
        end
    end

    // ##############################
    // Commit register
    // ##############################

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            commitValid <= 1'b0;
            commit.writeMask <= '0;
        end
        else
        begin
            commitValid <= barrier && anyEnabled;
            commit.writeMask <= barrier ? merged.writeMask : '0;   // Cleared without a barrier
        end
        commit.words <= merged.words;
    end

    // An idle commit never carries slots that the bank could pick up
    idleMaskClear: assert property (
        @(posedge clk) disable iff (!rstN)
        !commitValid |-> (commit.writeMask == '0)
    )
    else $error("storeMerge: write mask set while commitValid is low");

endmodule

`default_nettype wire

// File: source/wordBank.sv
`default_nettype none
`timescale 1ns/100ps

module wordBank (
    input logic clk,
    input logic rstN,
    input storeBufPkg::commitT commit,
    input logic commitValid,
    input storeBufPkg::rowT readRow,
    output storeBufPkg::wordT readWords [storeBufPkg::wordsPerLine]
);

    storeBufPkg::wordT bank [storeBufPkg::numSlots];

    // ##############################
    // Masked write
    // ##############################

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int s = 0; s < storeBufPkg::numSlots; s++)
            begin
                bank[s] <= '0;
            end
        end
        else if (commitValid)
        begin
            for (int s = 0; s < storeBufPkg::numSlots; s++)
            begin
                if (commit.writeMask[s])
                begin
                    bank[s] <= commit.words[s];
                end
            end
        end
    end

    // ##############################
    // Row read
    // ##############################

    // Old contents are seen when a commit lands on the same edge
    always_comb
    begin
        for (int w = 0; w < storeBufPkg::wordsPerLine; w++)
        begin
            readWords[w] = bank[int'(readRow) * storeBufPkg::wordsPerLine + w];
        end
    end

    // The row comes from the request slice and must always be defined
    readRowKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(readRow)
    )
    else $error("wordBank: readRow is unknown");

endmodule

`default_nettype wire

// File: source/storeBufTop.sv
`default_nettype none
`timescale 1ns/100ps

module storeBufTop (
    input logic clk,
    input logic rstN,

    // Cores
    input logic [storeBufPkg::numCores-1:0] coreEn,
    input storeBufPkg::slotT coreAddr [storeBufPkg::numCores],
    input storeBufPkg::wordT coreData [storeBufPkg::numCores],
    input logic [storeBufPkg::numCores-1:0] coreMemWr,

    // Flush request
    input logic flushValid,
    output logic flushReady,
    input storeBufPkg::rowT flushRow,

    // Memory line
    output logic lineValid,
    input logic lineReady,
    output storeBufPkg::rowT lineRow,
    output storeBufPkg::lineDataT lineData
);

    storeBufPkg::commitT commit;
    logic commitValid;

    logic reqValid;
    logic reqReady;
    storeBufPkg::rowT reqRow;

    storeBufPkg::wordT readWords [storeBufPkg::wordsPerLine];
    storeBufPkg::lineDataT packedWords;
    storeBufPkg::lineT lineIn;
    storeBufPkg::lineT lineOut;

    // ##############################
    // Store path
    // ##############################

    storeMerge merge (
        .clk(clk),
        .rstN(rstN),
        .coreEn(coreEn),
        .coreAddr(coreAddr),
        .coreData(coreData),
        .coreMemWr(coreMemWr),
        .commit(commit),
        .commitValid(commitValid)
    );

    wordBank bank (
        .clk(clk),
        .rstN(rstN),
        .commit(commit),
        .commitValid(commitValid),
        .readRow(reqRow),
        .readWords(readWords)
    );

    // ##############################
    // Flush path
    // ##############################

    handshakeSlice #(.payloadT(storeBufPkg::rowT)) flushReqSlice (
        .clk(clk),
        .rstN(rstN),
        .inValid(flushValid),
        .inReady(flushReady),
        .inData(flushRow),
        .outValid(reqValid),
        .outReady(reqReady),
        .outData(reqRow)
    );

    // Word 0 of the row lands in the top bits
    for (genvar w = 0; w < storeBufPkg::wordsPerLine; w++)
    begin : packLine
        localparam int lsb = (storeBufPkg::wordsPerLine - 1 - w) * storeBufPkg::wordWidth;
        assign packedWords[lsb +: storeBufPkg::wordWidth] = readWords[w];
    end

    assign lineIn = '{row: reqRow, data: packedWords};

    handshakeSlice #(.payloadT(storeBufPkg::lineT)) lineSlice (
        .clk(clk),
        .rstN(rstN),
        .inValid(reqValid),
        .inReady(reqReady),
        .inData(lineIn),
        .outValid(lineValid),
        .outReady(lineReady),
        .outData(lineOut)
    );

    assign lineRow = lineOut.row;
    assign lineData = lineOut.data;

endmodule

`default_nettype wire

// File: dv/storeBufClock.sv
`default_nettype none
`timescale 1ns/100ps

module storeBufClock #(
    parameter int halfPeriod = 4,           // 8 ns period
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rstN
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(halfPeriod) clk = ~clk;
        end
    end

    // Released just after an edge, like the other inputs
    initial
    begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/storeBufTb.sv
`default_nettype none
`timescale 1ns/100ps

module storeBufTb;

    typedef logic [storeBufPkg::numCores-1:0] coreMaskT;

    localparam int maxCycles = 20000;       // 300 random rounds of about 10 cycles, plus stalls
    localparam int driveDelay = 1;

    logic clk;
    logic rstN;
    coreMaskT coreEn;
    storeBufPkg::slotT coreAddr [storeBufPkg::numCores];
    storeBufPkg::wordT coreData [storeBufPkg::numCores];
    coreMaskT coreMemWr;
    logic flushValid;
    logic flushReady;
    storeBufPkg::rowT flushRow;
    logic lineValid;
    logic lineReady = 1'b1;
    storeBufPkg::rowT lineRow;
    storeBufPkg::lineDataT lineData;
    storeBufPkg::lineT gotLine;

    storeBufPkg::slotT stAddr [storeBufPkg::numCores];   // Next core cycle
    storeBufPkg::wordT stData [storeBufPkg::numCores];
    storeBufPkg::wordT refBank [storeBufPkg::numSlots];
    storeBufPkg::lineT expQ [$];
    storeBufPkg::lineT heldLine;
    logic holding = 1'b0;
    logic stallMode = 1'b0;
    int stretch = 0;
    int cycles = 0;
    string testName = "reset";

    storeBufClock clkGen (.clk(clk), .rstN(rstN));

    storeBufTop dut (
        .clk(clk),
        .rstN(rstN),
        .coreEn(coreEn),
        .coreAddr(coreAddr),
        .coreData(coreData),
        .coreMemWr(coreMemWr),
        .flushValid(flushValid),
        .flushReady(flushReady),
        .flushRow(flushRow),
        .lineValid(lineValid),
        .lineReady(lineReady),
        .lineRow(lineRow),
        .lineData(lineData)
    );

    assign gotLine.row = lineRow;
    assign gotLine.data = lineData;

    // ##############################
    // Reference model
    // ##############################

    function automatic void applyCoreCycle(
        input coreMaskT en,
        input storeBufPkg::slotT addr [storeBufPkg::numCores],
        input storeBufPkg::wordT data [storeBufPkg::numCores],
        input coreMaskT memWr
    );
        logic found;
        if (&memWr)                         // Barrier held
        begin
            for (int s = 0; s < storeBufPkg::numSlots; s++)
            begin
                found = 1'b0;
                for (int c = storeBufPkg::numCores - 1; c >= 0; c--)
                begin
                    if (!found && en[c] && addr[c] == storeBufPkg::slotT'(s))
                    begin
                        refBank[s] = data[c];   // Highest core first
                        found = 1'b1;
                    end
                end
            end
        end
    endfunction

    function automatic storeBufPkg::lineT expectLine(input storeBufPkg::rowT row);
        storeBufPkg::lineT line;
        int top;
        line.row = row;
        line.data = '0;
        for (int w = 0; w < storeBufPkg::wordsPerLine; w++)
        begin
            top = storeBufPkg::lineWidth - 1 - w * storeBufPkg::wordWidth;
            line.data[top -: storeBufPkg::wordWidth] =
                refBank[int'(row) * storeBufPkg::wordsPerLine + w];
        end
        return line;
    endfunction

    // ##############################
    // Checks
    // ##############################

    task automatic checkLine(input string name, input storeBufPkg::lineT expected,
                             input storeBufPkg::lineT actual);
        if (actual !== expected)
        begin
            $display("ERROR [%s] %s: expected row %0d data %h, actual row %0d data %h",
                     testName, name, expected.row, expected.data, actual.row, actual.data);
            $display("STATUS: FAIL");
            $fatal(1, "Line mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR [%s] %s: expected %b, actual %b", testName, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Flag mismatch");
        end
    endtask

    // Accepted requests, sampled mid-cycle
    always @(negedge clk)
    begin
        if (rstN && flushValid && flushReady)
        begin
            expQ.push_back(expectLine(flushRow));
        end
    end

    always @(negedge clk)
    begin
        if (rstN)
        begin
            if (holding)
            begin
                checkFlag("stalled lineValid", 1'b1, lineValid);
                checkLine("stalled line", heldLine, gotLine);
            end
            if (lineValid && lineReady)
            begin
                if (expQ.size() == 0)
                begin
                    $display("A line came out that no flush request asked for");
                    $display("STATUS: FAIL");
                    $fatal(1, "Unexpected line");
                end
                else
                begin
                    checkLine("flushed line", expQ.pop_front(), gotLine);
                end
            end
            holding = lineValid && !lineReady;
            heldLine = gotLine;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= maxCycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Random stretches of back-pressure
    always @(posedge clk)
    begin
        #(driveDelay);
        if (!stallMode)
        begin
            lineReady = 1'b1;
        end
        else if (stretch == 0)
        begin
            lineReady = ($urandom_range(0, 1) == 1);
            stretch = $urandom_range(1, 6);
        end
        else
        begin
            stretch--;
        end
    end

    // ##############################
    // Stimulus
    // ##############################

    task automatic fillRandom();
        for (int c = 0; c < storeBufPkg::numCores; c++)
        begin
            stAddr[c] = storeBufPkg::slotT'($urandom);
            stData[c] = storeBufPkg::wordT'($urandom);
        end
    endtask

    task automatic coreCycle(input coreMaskT en, input coreMaskT memWr);
        coreEn = en;
        coreMemWr = memWr;
        coreAddr = stAddr;
        coreData = stData;
        @(posedge clk);
        applyCoreCycle(en, stAddr, stData, memWr);
        #(driveDelay);
        coreEn = '0;
        coreMemWr = '0;
    endtask

    task automatic issueFlush(input storeBufPkg::rowT row);
        flushValid = 1'b1;
        flushRow = row;
        @(negedge clk);
        while (!flushReady) @(negedge clk);
        @(posedge clk);
        #(driveDelay);
        flushValid = 1'b0;
    endtask

    task automatic waitLines();
        do
        begin
            @(posedge clk);
            #(driveDelay);
        end
        while (expQ.size() != 0);
    endtask

    task automatic flushAllRows();
        for (int r = 0; r < storeBufPkg::numRows; r++)
        begin
            issueFlush(storeBufPkg::rowT'(r));
        end
        waitLines();
    endtask

    initial
    begin
        coreMaskT en;
        coreMaskT memWr;
        void'($urandom(32'hf107));
        flushValid = 1'b0;
        flushRow = '0;
        coreEn = '0;
        coreMemWr = '0;
        for (int c = 0; c < storeBufPkg::numCores; c++)
        begin
            coreAddr[c] = '0;
            coreData[c] = '0;
        end
        for (int s = 0; s < storeBufPkg::numSlots; s++)
        begin
            refBank[s] = '0;
        end
        wait (rstN === 1'b1);
        @(posedge clk);
        #(driveDelay);

        checkFlag("lineValid after reset", 1'b0, lineValid);
        checkFlag("flushReady after reset", 1'b1, flushReady);
        flushAllRows();

        testName = "distinct slots";
        for (int s = 0; s < storeBufPkg::numSlots; s++)
        begin
            fillRandom();
            en = '0;
            en[(s * 7 + 3) % storeBufPkg::numCores] = 1'b1;   // A different core per slot
            stAddr[(s * 7 + 3) % storeBufPkg::numCores] = storeBufPkg::slotT'(s);
            coreCycle(en, '1);
        end
        flushAllRows();

        testName = "no barrier";
        for (int i = 0; i < 8; i++)
        begin
            fillRandom();
            memWr = '1;
            memWr[$urandom_range(0, 15)] = 1'b0;
            coreCycle('1, memWr);
        end
        fillRandom();
        coreCycle('0, '1);                  // Barrier with no core enabled
        fillRandom();
        en = '0;
        en[9] = 1'b1;                       // Only core 9 may write
        for (int c = 0; c < storeBufPkg::numCores; c++)
        begin
            stAddr[c] = storeBufPkg::slotT'(c);
        end
        coreCycle(en, '1);
        flushAllRows();

        testName = "same slot";
        fillRandom();
        en = '0;
        for (int c = 2; c < storeBufPkg::numCores; c += 4)
        begin
            en[c] = 1'b1;
            stAddr[c] = storeBufPkg::slotT'(5);
            stData[c] = storeBufPkg::wordT'(32'h4000 + c);
        end
        coreCycle(en, '1);
        issueFlush(storeBufPkg::rowT'(1));
        waitLines();
        fillRandom();
        for (int c = 0; c < storeBufPkg::numCores; c++)
        begin
            stAddr[c] = storeBufPkg::slotT'(8 + $urandom_range(0, 3));
        end
        coreCycle('1, '1);
        issueFlush(storeBufPkg::rowT'(2));
        waitLines();

        testName = "back-pressure";
        stallMode = 1'b1;
        for (int i = 0; i < 24; i++)
        begin
            issueFlush(storeBufPkg::rowT'($urandom_range(0, 3)));
        end
        waitLines();
        stallMode = 1'b0;

        testName = "random";
        for (int i = 0; i < 300; i++)
        begin
            fillRandom();
            memWr = ($urandom_range(0, 3) == 0) ? coreMaskT'($urandom) : '1;
            coreCycle(coreMaskT'($urandom), memWr);
            if ($urandom_range(0, 1) == 1)
            begin
                issueFlush(storeBufPkg::rowT'($urandom_range(0, 3)));
                waitLines();
            end
        end
        flushAllRows();

        if (expQ.size() == 0 && !lineValid)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
        begin
            $display("Lines were still outstanding at the end of the run");
            $display("STATUS: FAIL");
            $fatal(1, "Outstanding lines");
        end
    end

endmodule

`default_nettype wire

// File: storeBuf.f
source/storeBufPkg.sv
source/handshakeSlice.sv
source/storeMerge.sv
source/wordBank.sv
source/storeBufTop.sv
dv/storeBufClock.sv
dv/storeBufTb.sv

// File: Makefile
# Verilator build and run for the store buffer testbench

VERILATOR ?= verilator
TOP ?= storeBufTb
FILELIST ?= storeBuf.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
